//--- verilog/lpif_enc_pkg.sv
/*
 * LPIF encodings package
 * Request and status codes, sideband states, link width and speed mode
 * as they appear on the adapter ports
 */
package lpif_enc_pkg;

  localparam int STATE_W     = 4;
  localparam int SB_W        = 4;
  localparam int LNK_CFG_W   = 3;
  localparam int SPEEDMODE_W = 3;

  // Link layer state request
  typedef logic [STATE_W-1:0] state_req_t;

  localparam state_req_t REQ_NOP        = 4'h0;
  localparam state_req_t REQ_ACTIVE     = 4'h1;
  localparam state_req_t REQ_IDLE_L1_1  = 4'h4;
  localparam state_req_t REQ_SLEEP_L2   = 4'h8;
  localparam state_req_t REQ_LINK_RESET = 4'h9;
  localparam state_req_t REQ_RETRAIN    = 4'hB;
  localparam state_req_t REQ_DISABLE    = 4'hC;

  // Status reported back to the link layer
  typedef logic [STATE_W-1:0] state_sts_t;

  localparam state_sts_t STS_RESET      = 4'h0;
  localparam state_sts_t STS_ACTIVE     = 4'h1;
  localparam state_sts_t STS_IDLE_L1_1  = 4'h4;
  localparam state_sts_t STS_SLEEP_L2   = 4'h8;
  localparam state_sts_t STS_LINK_RESET = 4'h9;
  localparam state_sts_t STS_LINK_ERROR = 4'hA;
  localparam state_sts_t STS_RETRAIN    = 4'hB;
  localparam state_sts_t STS_DISABLE    = 4'hC;

  // Sideband states, each STS code sits one above its REQ code
  typedef logic [SB_W-1:0] sb_state_t;

  localparam sb_state_t SB_NULL             = 4'h0;
  localparam sb_state_t SB_L1_REQ           = 4'h1;
  localparam sb_state_t SB_L1_STS           = 4'h2;
  localparam sb_state_t SB_ACTIVE_REQ       = 4'h3;
  localparam sb_state_t SB_ACTIVE_STS       = 4'h4;
  localparam sb_state_t SB_LINK_ERROR       = 4'h5;
  localparam sb_state_t SB_L2_REQ           = 4'h6;
  localparam sb_state_t SB_L2_STS           = 4'h7;
  localparam sb_state_t SB_LINK_RESET_REQ   = 4'h8;
  localparam sb_state_t SB_LINK_RESET_STS   = 4'h9;
  localparam sb_state_t SB_LINK_RETRAIN_REQ = 4'hA;
  localparam sb_state_t SB_LINK_RETRAIN_STS = 4'hB;

  typedef logic [LNK_CFG_W-1:0] lnk_cfg_t;

  localparam lnk_cfg_t LNK_CFG_X1  = 3'b000;
  localparam lnk_cfg_t LNK_CFG_X16 = 3'b101;

  typedef logic [SPEEDMODE_W-1:0] speedmode_t;

  localparam speedmode_t SPEEDMODE_GEN1 = 3'b000;
  localparam speedmode_t SPEEDMODE_GEN5 = 3'b100;

endpackage

//--- verilog/lsm_pkg.sv
/*
 * Link state machine package
 * State encoding shared by the FSM and its return-state register
 */
package lsm_pkg;

  localparam int LSM_STATE_W = 5;

  typedef enum logic [LSM_STATE_W-1:0] {
    RESET        = 5'h00,
    RESET_A      = 5'h01,
    ACTIVE_A     = 5'h02,
    ACTIVE       = 5'h03,
    ACTIVE_B     = 5'h04,
    IDLE_L1_1    = 5'h05,
    SLEEP_L2     = 5'h06,
    LINK_RESET_A = 5'h07,
    LINK_RESET   = 5'h08,
    LINK_ERROR   = 5'h09,
    RETRAIN_A    = 5'h0A,
    RETRAIN_B    = 5'h0B,
    RETRAIN_C    = 5'h0C,
    RETRAIN      = 5'h0D,
    DISABLE      = 5'h0E,
    SB_ACK       = 5'h0F
  } lsm_state_e;

endpackage

//--- verilog/lsm_req_tracker.sv
`timescale 1ns/100ps
/*
 * Request tracker
 * Registers the link layer state request and raises a sticky flag
 * when a new non-NOP request shows up, held until the FSM consumes it
 */
module lsm_req_tracker
(
  input  logic                     lclk,
  input  logic                     rst_n,
  input  lpif_enc_pkg::state_req_t lp_state_req,
  input  logic                     req_change_clr,
  output lpif_enc_pkg::state_req_t state_req,
  output logic                     req_change
);

  logic new_req;

  // Compare against the value registered on the previous edge
  assign new_req = (lp_state_req != state_req) &&
                   (lp_state_req != lpif_enc_pkg::REQ_NOP);

  always_ff @(posedge lclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_req  <= lpif_enc_pkg::REQ_NOP;
      req_change <= 1'b0;
    end
    else
    begin
      state_req <= lp_state_req;
      // A fresh request wins over a clear in the same cycle
      if (new_req)
        req_change <= 1'b1;
      else if (req_change_clr)
        req_change <= 1'b0;
    end
  end

endmodule

//--- verilog/lsm_handshake.sv
`timescale 1ns/100ps
/*
 * Four-phase req/ack initiator
 * Raises req on a start pulse and drops it once the registered ack
 * has been seen high, then waits for ack to fall
 */
module lsm_handshake
(
  input  logic lclk,
  input  logic rst_n,
  input  logic start,
  input  logic ack,
  output logic req,
  output logic granted,
  output logic idle
);

  logic ack_q;

  always_ff @(posedge lclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      req   <= 1'b0;
      ack_q <= 1'b0;
    end
    else
    begin
      ack_q <= ack;
      if (start)
        req <= 1'b1;
      else if (ack_q)
        req <= 1'b0;
    end
  end

  // Phase seen by the FSM
  assign granted = req & ack;
  assign idle    = ~req & ~ack;

endmodule

//--- verilog/lsm_wake_ack.sv
`timescale 1ns/100ps
/*
 * Wake acknowledge
 * Two-flop synchronizer on the asynchronous wake request, followed
 * by the acknowledge register
 */
module lsm_wake_ack
(
  input  logic lclk,
  input  logic rst_n,
  input  logic lp_wake_req,
  output logic pl_wake_ack
);

  logic wake_meta;
  logic wake_sync;

  always_ff @(posedge lclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wake_meta   <= 1'b0;
      wake_sync   <= 1'b0;
      pl_wake_ack <= 1'b0;
    end
    else
    begin
      wake_meta   <= lp_wake_req;
      wake_sync   <= wake_meta;
      pl_wake_ack <= wake_sync;
    end
  end

endmodule

//--- verilog/lsm_fsm.sv
`timescale 1ns/100ps
/*
 * Link state machine
 * Decodes link layer requests and remote sideband states, walks the
 * reset, active, L1, L2, link reset, retrain, error and disable states
 * and drives status, downstream sideband state and PHY controls
 */
module lsm_fsm
(
  input  logic                     lclk,
  input  logic                     rst_n,
  input  lpif_enc_pkg::state_req_t state_req,
  input  logic                     req_change,
  input  lpif_enc_pkg::sb_state_t  ustrm_state,
  input  logic                     ctl_link_up,
  input  logic                     ctl_phy_err,
  input  logic                     cg_granted,
  input  logic                     cg_idle,
  input  logic                     stall_granted,
  output logic                     req_change_clr,
  output logic                     cg_start,
  output logic                     stall_start,
  output lpif_enc_pkg::state_sts_t pl_state_sts,
  output lpif_enc_pkg::sb_state_t  lsm_dstrm_state,
  output lpif_enc_pkg::lnk_cfg_t   lsm_lnk_cfg,
  output lpif_enc_pkg::speedmode_t lsm_speedmode,
  output logic                     pl_lnk_up,
  output logic                     pl_phyinl1,
  output logic                     pl_phyinl2,
  output logic                     pl_phyinrecenter,
  output logic                     lsm_state_active
);

  lsm_pkg::lsm_state_e state, d_state;
  lsm_pkg::lsm_state_e return_state, d_return_state;

  logic coldstart, d_coldstart;
  logic exit_lp, d_exit_lp;

  lpif_enc_pkg::state_sts_t d_sts;
  lpif_enc_pkg::sb_state_t  d_dstrm;
  lpif_enc_pkg::lnk_cfg_t   d_lnk_cfg;
  lpif_enc_pkg::speedmode_t d_speedmode;
  logic d_lnk_up, d_phyinl1, d_phyinl2, d_recenter;

  logic req_active, req_retrain, req_l1, req_l2, req_lreset, req_disable;
  logic sb_l1_req, sb_active_req, sb_l2_req, sb_lreset_req, sb_lreset_sts;
  logic sb_retrain_req, sb_retrain_sts, sb_link_error;
  logic sb_ack, exit_active;

  //////////////////////////////////////////////////
  // Request and sideband decodes
  //////////////////////////////////////////////////

  assign req_active  = (state_req == lpif_enc_pkg::REQ_ACTIVE);
  assign req_retrain = (state_req == lpif_enc_pkg::REQ_RETRAIN);
  assign req_l1      = (state_req == lpif_enc_pkg::REQ_IDLE_L1_1);
  assign req_l2      = (state_req == lpif_enc_pkg::REQ_SLEEP_L2);
  assign req_lreset  = (state_req == lpif_enc_pkg::REQ_LINK_RESET);
  assign req_disable = (state_req == lpif_enc_pkg::REQ_DISABLE);

  assign sb_l1_req      = (ustrm_state == lpif_enc_pkg::SB_L1_REQ);
  assign sb_active_req  = (ustrm_state == lpif_enc_pkg::SB_ACTIVE_REQ);
  assign sb_l2_req      = (ustrm_state == lpif_enc_pkg::SB_L2_REQ);
  assign sb_lreset_req  = (ustrm_state == lpif_enc_pkg::SB_LINK_RESET_REQ);
  assign sb_lreset_sts  = (ustrm_state == lpif_enc_pkg::SB_LINK_RESET_STS);
  assign sb_retrain_req = (ustrm_state == lpif_enc_pkg::SB_LINK_RETRAIN_REQ);
  assign sb_retrain_sts = (ustrm_state == lpif_enc_pkg::SB_LINK_RETRAIN_STS);
  assign sb_link_error  = (ustrm_state == lpif_enc_pkg::SB_LINK_ERROR);

  // Remote echoes the request we sent downstream
  assign sb_ack =
    ((lsm_dstrm_state == lpif_enc_pkg::SB_L1_REQ) &&
     (ustrm_state == lpif_enc_pkg::SB_L1_STS)) ||
    ((lsm_dstrm_state == lpif_enc_pkg::SB_ACTIVE_REQ) &&
     (ustrm_state == lpif_enc_pkg::SB_ACTIVE_STS)) ||
    ((lsm_dstrm_state == lpif_enc_pkg::SB_LINK_RESET_REQ) && sb_lreset_sts);

  assign exit_active = coldstart | sb_l1_req | sb_l2_req | sb_lreset_req |
                       sb_retrain_req | sb_link_error |
                       (req_change & (req_retrain | req_l1 | req_l2 |
                                      req_lreset | req_disable));

  assign lsm_state_active = (pl_state_sts == lpif_enc_pkg::STS_ACTIVE);

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb
  begin
    d_state        = state;
    d_return_state = return_state;
    d_coldstart    = coldstart;
    d_exit_lp      = exit_lp;
    d_sts          = pl_state_sts;
    d_dstrm        = lsm_dstrm_state;
    d_lnk_cfg      = lsm_lnk_cfg;
    d_speedmode    = lsm_speedmode;
    d_lnk_up       = pl_lnk_up;
    d_phyinl1      = 1'b0;
    d_phyinl2      = 1'b0;
    d_recenter     = 1'b0;
    req_change_clr = 1'b0;
    cg_start       = 1'b0;
    stall_start    = 1'b0;
    if (ctl_phy_err)
    begin
      d_sts   = lpif_enc_pkg::STS_LINK_ERROR;
      d_state = lsm_pkg::LINK_ERROR;
    end
    else
    begin
      case (state)
        lsm_pkg::RESET:
        begin
          d_sts = lpif_enc_pkg::STS_RESET;
          if (ctl_link_up)
            d_state = lsm_pkg::RESET_A;
        end
        lsm_pkg::RESET_A:
        begin
          d_lnk_up = 1'b1;
          if ((req_active || sb_active_req) && cg_idle)
          begin
            cg_start = 1'b1;
            d_state  = lsm_pkg::ACTIVE_A;
          end
          else if (req_lreset && req_change)
          begin
            req_change_clr = 1'b1;
            d_state        = lsm_pkg::LINK_RESET;
          end
          else if (req_disable && req_change)
          begin
            req_change_clr = 1'b1;
            d_state        = lsm_pkg::DISABLE;
          end
          else if (sb_link_error)
            d_state = lsm_pkg::LINK_ERROR;
        end
        lsm_pkg::ACTIVE_A:
        begin
          // Clock-gate exit granted by the link layer
          if (cg_granted)
          begin
            d_sts   = lpif_enc_pkg::STS_ACTIVE;
            d_dstrm = lpif_enc_pkg::SB_ACTIVE_STS;
            d_state = lsm_pkg::ACTIVE;
          end
        end
        lsm_pkg::ACTIVE:
        begin
          if (exit_active)
          begin
            req_change_clr = 1'b1;
            stall_start    = 1'b1;
            d_state        = lsm_pkg::ACTIVE_B;
          end
        end
        lsm_pkg::ACTIVE_B:
        begin
          // Traffic stalled, pick the exit
          if (stall_granted)
          begin
            if (req_retrain || coldstart)
            begin
              d_sts   = lpif_enc_pkg::STS_RETRAIN;
              d_dstrm = lpif_enc_pkg::SB_LINK_RETRAIN_STS;
              d_state = lsm_pkg::RETRAIN_A;
            end
            else if (req_l1)
            begin
              d_dstrm        = lpif_enc_pkg::SB_L1_REQ;
              d_return_state = lsm_pkg::IDLE_L1_1;
              d_state        = lsm_pkg::SB_ACK;
            end
            else if (sb_l1_req)
            begin
              d_sts   = lpif_enc_pkg::STS_IDLE_L1_1;
              d_state = lsm_pkg::IDLE_L1_1;
            end
            else if (req_l2 || sb_l2_req)
            begin
              d_sts   = lpif_enc_pkg::STS_SLEEP_L2;
              d_state = lsm_pkg::SLEEP_L2;
            end
            else if (req_lreset)
            begin
              d_dstrm        = lpif_enc_pkg::SB_LINK_RESET_REQ;
              d_return_state = lsm_pkg::LINK_RESET_A;
              d_state        = lsm_pkg::SB_ACK;
            end
            else if (sb_lreset_req)
              d_state = lsm_pkg::LINK_RESET_A;
            else if (sb_retrain_req)
              d_state = lsm_pkg::RETRAIN;
            else if (req_disable)
              d_state = lsm_pkg::DISABLE;
            else if (sb_link_error)
              d_state = lsm_pkg::LINK_ERROR;
          end
        end
        lsm_pkg::IDLE_L1_1:
        begin
          d_sts     = lpif_enc_pkg::STS_IDLE_L1_1;
          d_dstrm   = lpif_enc_pkg::SB_L1_STS;
          d_phyinl1 = 1'b1;
          if (sb_active_req)
            d_state = lsm_pkg::RETRAIN_A;
          else if ((req_active || req_retrain) && req_change)
          begin
            req_change_clr = 1'b1;
            d_exit_lp      = 1'b1;
            d_dstrm        = lpif_enc_pkg::SB_ACTIVE_REQ;
            d_return_state = lsm_pkg::RETRAIN_A;
            d_state        = lsm_pkg::SB_ACK;
          end
          else if (req_lreset && req_change)
          begin
            req_change_clr = 1'b1;
            d_dstrm        = lpif_enc_pkg::SB_LINK_RESET_REQ;
            d_return_state = lsm_pkg::LINK_RESET_A;
            d_state        = lsm_pkg::SB_ACK;
          end
          else if (sb_lreset_req)
            d_state = lsm_pkg::LINK_RESET_A;
          else if (req_disable && req_change)
          begin
            req_change_clr = 1'b1;
            d_state        = lsm_pkg::DISABLE;
          end
          else if (sb_link_error)
            d_state = lsm_pkg::LINK_ERROR;
        end
        lsm_pkg::SLEEP_L2:
        begin
          d_sts     = lpif_enc_pkg::STS_SLEEP_L2;
          d_dstrm   = lpif_enc_pkg::SB_L2_STS;
          d_phyinl2 = 1'b1;
          if ((req_active || req_retrain) && req_change)
          begin
            req_change_clr = 1'b1;
            d_exit_lp      = 1'b1;
            d_sts          = lpif_enc_pkg::STS_RETRAIN;
            d_state        = lsm_pkg::RETRAIN_A;
          end
          else if (req_lreset && req_change)
          begin
            req_change_clr = 1'b1;
            d_dstrm        = lpif_enc_pkg::SB_LINK_RESET_REQ;
            d_state        = lsm_pkg::LINK_RESET_A;
          end
          else if (req_disable && req_change)
          begin
            req_change_clr = 1'b1;
            d_state        = lsm_pkg::DISABLE;
          end
          else if (sb_link_error)
            d_state = lsm_pkg::LINK_ERROR;
        end
        lsm_pkg::LINK_RESET_A:
        begin
          if (sb_lreset_req || sb_lreset_sts)
          begin
            d_sts    = lpif_enc_pkg::STS_LINK_RESET;
            d_lnk_up = 1'b0;
            d_state  = lsm_pkg::LINK_RESET;
          end
        end
        lsm_pkg::LINK_RESET:
        begin
          d_dstrm = lpif_enc_pkg::SB_LINK_RESET_STS;
          if (sb_active_req)
            d_state = lsm_pkg::RESET;
          else if (req_active && req_change)
          begin
            req_change_clr = 1'b1;
            d_dstrm        = lpif_enc_pkg::SB_ACTIVE_REQ;
            d_return_state = lsm_pkg::RESET;
            d_state        = lsm_pkg::SB_ACK;
          end
          else if (req_disable && req_change)
          begin
            req_change_clr = 1'b1;
            d_state        = lsm_pkg::DISABLE;
          end
          else if (sb_link_error)
            d_state = lsm_pkg::LINK_ERROR;
        end
        lsm_pkg::LINK_ERROR:
        begin
          // Left only through reset
          d_sts   = lpif_enc_pkg::STS_LINK_ERROR;
          d_dstrm = lpif_enc_pkg::SB_LINK_ERROR;
        end
        lsm_pkg::RETRAIN_A:
        begin
          if (!sb_active_req)
            d_dstrm = lpif_enc_pkg::SB_LINK_RETRAIN_STS;
          d_state = lsm_pkg::RETRAIN_B;
        end
        lsm_pkg::RETRAIN_B:
        begin
          d_state = lsm_pkg::RETRAIN_C;
        end
        lsm_pkg::RETRAIN_C:
        begin
          if ((sb_active_req || coldstart || exit_lp || sb_retrain_sts) && cg_idle)
          begin
            d_sts   = lpif_enc_pkg::STS_RETRAIN;
            d_state = lsm_pkg::RETRAIN;
          end
        end
        lsm_pkg::RETRAIN:
        begin
          d_lnk_cfg   = lpif_enc_pkg::LNK_CFG_X16;
          d_speedmode = lpif_enc_pkg::SPEEDMODE_GEN5;
          d_recenter  = 1'b1;
          d_dstrm     = lpif_enc_pkg::SB_LINK_RETRAIN_STS;
          if (((req_active && req_change) || coldstart || exit_lp) && cg_idle)
          begin
            req_change_clr = 1'b1;
            cg_start       = 1'b1;
            d_coldstart    = 1'b0;
            d_exit_lp      = 1'b0;
            d_state        = lsm_pkg::ACTIVE_A;
          end
          else if (sb_active_req && cg_idle)
          begin
            cg_start = 1'b1;
            d_dstrm  = lpif_enc_pkg::SB_ACTIVE_STS;
            d_state  = lsm_pkg::ACTIVE_A;
          end
          else if (req_lreset && req_change)
          begin
            req_change_clr = 1'b1;
            d_dstrm        = lpif_enc_pkg::SB_LINK_RESET_REQ;
            d_state        = lsm_pkg::LINK_RESET_A;
          end
          else if (req_disable && req_change)
          begin
            req_change_clr = 1'b1;
            d_state        = lsm_pkg::DISABLE;
          end
          else if (sb_link_error)
            d_state = lsm_pkg::LINK_ERROR;
        end
        lsm_pkg::DISABLE:
        begin
          d_sts = lpif_enc_pkg::STS_DISABLE;
          if (sb_link_error)
            d_state = lsm_pkg::LINK_ERROR;
          else if (req_active && req_change)
          begin
            req_change_clr = 1'b1;
            d_state        = lsm_pkg::RESET;
          end
        end
        lsm_pkg::SB_ACK:
        begin
          if (sb_ack)
            d_state = return_state;
        end
        default:
        begin
          d_state = lsm_pkg::RESET;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // State and registered outputs
  //////////////////////////////////////////////////

  always_ff @(posedge lclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state            <= lsm_pkg::RESET;
      return_state     <= lsm_pkg::RESET;
      coldstart        <= 1'b1;
      exit_lp          <= 1'b0;
      pl_state_sts     <= lpif_enc_pkg::STS_RESET;
      lsm_dstrm_state  <= lpif_enc_pkg::SB_NULL;
      lsm_lnk_cfg      <= lpif_enc_pkg::LNK_CFG_X1;
      lsm_speedmode    <= lpif_enc_pkg::SPEEDMODE_GEN1;
      pl_lnk_up        <= 1'b0;
      pl_phyinl1       <= 1'b0;
      pl_phyinl2       <= 1'b0;
      pl_phyinrecenter <= 1'b0;
    end
    else
    begin
      state            <= d_state;
      return_state     <= d_return_state;
      coldstart        <= d_coldstart;
      exit_lp          <= d_exit_lp;
      pl_state_sts     <= d_sts;
      lsm_dstrm_state  <= d_dstrm;
      lsm_lnk_cfg      <= d_lnk_cfg;
      lsm_speedmode    <= d_speedmode;
      pl_lnk_up        <= d_lnk_up;
      pl_phyinl1       <= d_phyinl1;
      pl_phyinl2       <= d_phyinl2;
      pl_phyinrecenter <= d_recenter;
    end
  end

endmodule

//--- verilog/lpif_lsm.sv
`timescale 1ns/100ps
/*
 * LPIF adapter link state machine, top level
 * Request tracker, link FSM, clock-gate exit and stall handshakes
 * and wake acknowledge
 */
module lpif_lsm
(
  input  logic                     lclk,
  input  logic                     rst_n,
  input  lpif_enc_pkg::state_req_t lp_state_req,
  input  lpif_enc_pkg::sb_state_t  ustrm_state,
  input  logic                     ctl_link_up,
  input  logic                     ctl_phy_err,
  input  logic                     lp_exit_cg_ack,
  input  logic                     lp_stallack,
  input  logic                     lp_wake_req,
  output lpif_enc_pkg::state_sts_t pl_state_sts,
  output lpif_enc_pkg::sb_state_t  lsm_dstrm_state,
  output lpif_enc_pkg::lnk_cfg_t   lsm_lnk_cfg,
  output lpif_enc_pkg::speedmode_t lsm_speedmode,
  output logic                     pl_exit_cg_req,
  output logic                     pl_stallreq,
  output logic                     pl_wake_ack,
  output logic                     pl_phyinl1,
  output logic                     pl_phyinl2,
  output logic                     pl_phyinrecenter,
  output logic                     pl_lnk_up,
  output logic                     lsm_state_active
);

  lpif_enc_pkg::state_req_t state_req;
  logic req_change, req_change_clr;
  logic cg_start, cg_granted, cg_idle;
  logic stall_start, stall_granted;

  lsm_req_tracker i_req_tracker (
    .lclk           (lclk),
    .rst_n          (rst_n),
    .lp_state_req   (lp_state_req),
    .req_change_clr (req_change_clr),
    .state_req      (state_req),
    .req_change     (req_change)
  );

  lsm_fsm i_fsm (
    .lclk             (lclk),
    .rst_n            (rst_n),
    .state_req        (state_req),
    .req_change       (req_change),
    .ustrm_state      (ustrm_state),
    .ctl_link_up      (ctl_link_up),
    .ctl_phy_err      (ctl_phy_err),
    .cg_granted       (cg_granted),
    .cg_idle          (cg_idle),
    .stall_granted    (stall_granted),
    .req_change_clr   (req_change_clr),
    .cg_start         (cg_start),
    .stall_start      (stall_start),
    .pl_state_sts     (pl_state_sts),
    .lsm_dstrm_state  (lsm_dstrm_state),
    .lsm_lnk_cfg      (lsm_lnk_cfg),
    .lsm_speedmode    (lsm_speedmode),
    .pl_lnk_up        (pl_lnk_up),
    .pl_phyinl1       (pl_phyinl1),
    .pl_phyinl2       (pl_phyinl2),
    .pl_phyinrecenter (pl_phyinrecenter),
    .lsm_state_active (lsm_state_active)
  );

  // Clock-gate exit
  lsm_handshake i_cg_hs (
    .lclk    (lclk),
    .rst_n   (rst_n),
    .start   (cg_start),
    .ack     (lp_exit_cg_ack),
    .req     (pl_exit_cg_req),
    .granted (cg_granted),
    .idle    (cg_idle)
  );

  // Stall, the FSM only needs the grant
  lsm_handshake i_stall_hs (
    .lclk    (lclk),
    .rst_n   (rst_n),
    .start   (stall_start),
    .ack     (lp_stallack),
    .req     (pl_stallreq),
    .granted (stall_granted),
    .idle    ()
  );

  lsm_wake_ack i_wake_ack (
    .lclk        (lclk),
    .rst_n       (rst_n),
    .lp_wake_req (lp_wake_req),
    .pl_wake_ack (pl_wake_ack)
  );

endmodule

//--- dv/tb_lpif_lsm.sv
`timescale 1ns/100ps
/*
 * Testbench for the LPIF link state machine
 * Reads request, sideband and expected-status vectors from a data file,
 * answers the clock-gate exit and stall handshakes, and checks reset
 * values, the per-state side outputs and the wake acknowledge delay
 */
module tb_lpif_lsm;

  localparam int MAX_STEPS = 64;
  localparam int FIELDS    = 8;
  localparam int SLACK     = 100;

  logic                     lclk;
  logic                     rst_n;
  lpif_enc_pkg::state_req_t lp_state_req;
  lpif_enc_pkg::sb_state_t  ustrm_state;
  logic                     ctl_link_up;
  logic                     ctl_phy_err;
  logic                     lp_exit_cg_ack;
  logic                     lp_stallack;
  logic                     lp_wake_req;
  lpif_enc_pkg::state_sts_t pl_state_sts;
  lpif_enc_pkg::sb_state_t  lsm_dstrm_state;
  lpif_enc_pkg::lnk_cfg_t   lsm_lnk_cfg;
  lpif_enc_pkg::speedmode_t lsm_speedmode;
  logic                     pl_exit_cg_req;
  logic                     pl_stallreq;
  logic                     pl_wake_ack;
  logic                     pl_phyinl1;
  logic                     pl_phyinl2;
  logic                     pl_phyinrecenter;
  logic                     pl_lnk_up;
  logic                     lsm_state_active;

  logic [31:0] vec_mem [0:MAX_STEPS*FIELDS-1];
  integer      seed = 32'h781e_21bc;
  int          num_steps;
  int          cycle_count;
  int          cycle_limit;
  int          errors;
  int          checks;
  string       phase;
  logic        recenter_seen;

  lpif_lsm i_lpif_lsm (
    .lclk             (lclk),
    .rst_n            (rst_n),
    .lp_state_req     (lp_state_req),
    .ustrm_state      (ustrm_state),
    .ctl_link_up      (ctl_link_up),
    .ctl_phy_err      (ctl_phy_err),
    .lp_exit_cg_ack   (lp_exit_cg_ack),
    .lp_stallack      (lp_stallack),
    .lp_wake_req      (lp_wake_req),
    .pl_state_sts     (pl_state_sts),
    .lsm_dstrm_state  (lsm_dstrm_state),
    .lsm_lnk_cfg      (lsm_lnk_cfg),
    .lsm_speedmode    (lsm_speedmode),
    .pl_exit_cg_req   (pl_exit_cg_req),
    .pl_stallreq      (pl_stallreq),
    .pl_wake_ack      (pl_wake_ack),
    .pl_phyinl1       (pl_phyinl1),
    .pl_phyinl2       (pl_phyinl2),
    .pl_phyinrecenter (pl_phyinrecenter),
    .pl_lnk_up        (pl_lnk_up),
    .lsm_state_active (lsm_state_active)
  );

  always #2 lclk = ~lclk;

  // Recenter pulses come from the retrain state, remembered until active
  always @(negedge lclk)
  begin
    if (pl_phyinrecenter === 1'b1)
      recenter_seen = 1'b1;
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("CHECK FAILED: %s = %h, expected %h (%s)", name, actual, expected, phase);
    end
  endtask

  task automatic check_reset_values();
    phase = "reset";
    check_value("pl_state_sts", 32'(pl_state_sts), 32'(lpif_enc_pkg::STS_RESET));
    check_value("lsm_dstrm_state", 32'(lsm_dstrm_state), 32'(lpif_enc_pkg::SB_NULL));
    check_value("lsm_lnk_cfg", 32'(lsm_lnk_cfg), 32'(lpif_enc_pkg::LNK_CFG_X1));
    check_value("lsm_speedmode", 32'(lsm_speedmode), 32'(lpif_enc_pkg::SPEEDMODE_GEN1));
    check_value("pl_exit_cg_req", 32'(pl_exit_cg_req), 32'd0);
    check_value("pl_stallreq", 32'(pl_stallreq), 32'd0);
    check_value("pl_wake_ack", 32'(pl_wake_ack), 32'd0);
    check_value("pl_phyinl1", 32'(pl_phyinl1), 32'd0);
    check_value("pl_phyinl2", 32'(pl_phyinl2), 32'd0);
    check_value("pl_phyinrecenter", 32'(pl_phyinrecenter), 32'd0);
    check_value("pl_lnk_up", 32'(pl_lnk_up), 32'd0);
    check_value("lsm_state_active", 32'(lsm_state_active), 32'd0);
  endtask

  // Outputs implied by the status just reached
  task automatic check_state_outputs(input lpif_enc_pkg::state_sts_t sts);
    case (sts)
      lpif_enc_pkg::STS_ACTIVE:
      begin
        check_value("lsm_lnk_cfg", 32'(lsm_lnk_cfg), 32'(lpif_enc_pkg::LNK_CFG_X16));
        check_value("lsm_speedmode", 32'(lsm_speedmode),
                    32'(lpif_enc_pkg::SPEEDMODE_GEN5));
        check_value("lsm_state_active", 32'(lsm_state_active), 32'd1);
        check_value("pl_lnk_up", 32'(pl_lnk_up), 32'd1);
        // Every active entry here follows a retrain
        check_value("pl_phyinrecenter", 32'(recenter_seen), 32'd1);
        recenter_seen = 1'b0;
      end
      lpif_enc_pkg::STS_RETRAIN:
        check_value("pl_lnk_up", 32'(pl_lnk_up), 32'd1);
      lpif_enc_pkg::STS_IDLE_L1_1:
        check_value("pl_phyinl1", 32'(pl_phyinl1), 32'd1);
      lpif_enc_pkg::STS_SLEEP_L2:
        check_value("pl_phyinl2", 32'(pl_phyinl2), 32'd1);
      lpif_enc_pkg::STS_LINK_RESET:
        check_value("pl_lnk_up", 32'(pl_lnk_up), 32'd0);
      default:
        ;
    endcase
  endtask

  // Drive one vector, then poll at each falling edge until the status
  // and downstream state match or the step's wait limit runs out
  task automatic run_step(input int idx);
    int                       base;
    int                       limit;
    int                       waited;
    logic                     matched;
    lpif_enc_pkg::state_sts_t exp_sts;
    lpif_enc_pkg::sb_state_t  exp_dstrm;
    base         = idx * FIELDS;
    phase        = $sformatf("step %0d", idx + 1);
    exp_sts      = vec_mem[base+5][3:0];
    exp_dstrm    = vec_mem[base+6][3:0];
    limit        = int'(vec_mem[base+7]);
    lp_state_req = vec_mem[base][3:0];
    ustrm_state  = vec_mem[base+1][3:0];
    ctl_link_up  = vec_mem[base+2][0];
    ctl_phy_err  = vec_mem[base+3][0];
    lp_wake_req  = vec_mem[base+4][0];
    waited       = 0;
    matched      = 1'b0;
    while (!matched && waited < limit)
    begin
      @(negedge lclk);
      waited++;
      matched = (pl_state_sts == exp_sts) && (lsm_dstrm_state == exp_dstrm);
    end
    if (matched)
      check_state_outputs(exp_sts);
    else
    begin
      check_value("pl_state_sts", 32'(pl_state_sts), 32'(exp_sts));
      check_value("lsm_dstrm_state", 32'(lsm_dstrm_state), 32'(exp_dstrm));
    end
  endtask

  // Two synchronizer flops and the ack register, so three edges each way
  task automatic check_wake_delay();
    phase       = "wake";
    lp_wake_req = 1'b1;
    repeat (2) @(negedge lclk);
    check_value("pl_wake_ack", 32'(pl_wake_ack), 32'd0);
    @(negedge lclk);
    check_value("pl_wake_ack", 32'(pl_wake_ack), 32'd1);
    lp_wake_req = 1'b0;
    repeat (2) @(negedge lclk);
    check_value("pl_wake_ack", 32'(pl_wake_ack), 32'd1);
    @(negedge lclk);
    check_value("pl_wake_ack", 32'(pl_wake_ack), 32'd0);
  endtask

  //////////////////////////////////////////////////
  // Link layer responders
  //////////////////////////////////////////////////

  initial
  begin
    int unsigned dly;
    lp_exit_cg_ack = 1'b0;
    forever
    begin
      @(negedge lclk);
      if (pl_exit_cg_req === 1'b1)
      begin
        dly = 1 + ({$random(seed)} % 4);
        repeat (dly) @(negedge lclk);
        lp_exit_cg_ack = 1'b1;
        while (pl_exit_cg_req === 1'b1)
          @(negedge lclk);
        lp_exit_cg_ack = 1'b0;
      end
    end
  end

  initial
  begin
    int unsigned dly;
    lp_stallack = 1'b0;
    forever
    begin
      @(negedge lclk);
      if (pl_stallreq === 1'b1)
      begin
        dly = 1 + ({$random(seed)} % 4);
        repeat (dly) @(negedge lclk);
        lp_stallack = 1'b1;
        while (pl_stallreq === 1'b1)
          @(negedge lclk);
        lp_stallack = 1'b0;
      end
    end
  end

  // Run limit, sum of the step limits plus slack
  always @(posedge lclk)
  begin
    cycle_count++;
    if (cycle_count > cycle_limit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("checks: %0d, errors: %0d", checks, errors + 1);
      $display("** FAIL **");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial
  begin
    int i;
    lclk          = 1'b0;
    rst_n         = 1'b0;
    lp_state_req  = lpif_enc_pkg::REQ_NOP;
    ustrm_state   = lpif_enc_pkg::SB_NULL;
    ctl_link_up   = 1'b0;
    ctl_phy_err   = 1'b0;
    lp_wake_req   = 1'b0;
    errors        = 0;
    checks        = 0;
    recenter_seen = 1'b0;
    phase         = "setup";
    $readmemh("dv/lsm_input.txt", vec_mem);
    // A zero wait limit marks the end of the list
    num_steps   = 0;
    cycle_limit = SLACK;
    while (num_steps < MAX_STEPS && vec_mem[num_steps*FIELDS+7] != 0)
    begin
      cycle_limit = cycle_limit + int'(vec_mem[num_steps*FIELDS+7]);
      num_steps++;
    end
    if (num_steps == 0)
    begin
      errors++;
      $display("No test vectors could be read from dv/lsm_input.txt");
    end
    repeat (4) @(posedge lclk);
    @(negedge lclk);
    rst_n = 1'b1;
    @(negedge lclk);
    check_reset_values();
    for (i = 0; i < num_steps; i++)
      run_step(i);
    check_wake_delay();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

//--- dv/lsm_input.txt
// Columns (hex): lp_state_req ustrm_state ctl_link_up ctl_phy_err lp_wake_req
//                expected pl_state_sts, expected lsm_dstrm_state, wait limit in cycles
0 0 1 0 0 0 0 08 // link up, still in reset
1 0 1 0 0 B B 28 // coldstart goes through retrain
1 0 1 0 0 1 4 28 // active, x16 gen5
1 1 1 0 0 4 2 1E // remote L1 request
1 3 1 0 0 1 4 28 // remote active request, back to active
8 0 1 0 0 8 7 1E // L2 entry
1 0 1 0 0 B B 1E // L2 exit through retrain
1 0 1 0 0 1 4 1E // active again
1 8 1 0 0 9 9 1E // remote link reset
C 0 1 0 0 C 9 14 // disable
C 0 1 1 0 A 9 0A // PHY error
C 0 1 0 0 A 5 0A // link error on the sideband
0 0 0 0 0 0 0 00 // end of list

//--- Makefile
# Verilator build, run and lint for the LPIF link state machine

VERILATOR  ?= verilator
TOP        ?= tb_lpif_lsm
RTL_TOP    ?= lpif_lsm
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
TIMESCALE  ?= 1ns/100ps
VFLAGS     ?= --binary --timing --timescale $(TIMESCALE)
LINT_FLAGS ?= --lint-only --timing -Wall --timescale $(TIMESCALE)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- src.f
verilog/lpif_enc_pkg.sv
verilog/lsm_pkg.sv
verilog/lsm_req_tracker.sv
verilog/lsm_handshake.sv
verilog/lsm_wake_ack.sv
verilog/lsm_fsm.sv
verilog/lpif_lsm.sv
dv/tb_lpif_lsm.sv
